// ==== hw/etx_defines.svh ====
`ifndef ETX_DEFINES_SVH
`define ETX_DEFINES_SVH

// ##################################################
// Link transmit sizing
// ##################################################

// Packets held between capture and serializer
// Keep this a power of two so the pointers wrap on their own
`define ETX_FIFO_DEPTH 4

// Pointer width of the packet FIFO
`define ETX_FIFO_AW $clog2(`ETX_FIFO_DEPTH)

// Full emesh packet width
`define ETX_PW 104

`endif

// ==== hw/etx_pkg.sv ====
`include "etx_defines.svh"

package etx_pkg;

   // ##################################################
   // Access width of a transaction
   // ##################################################
   typedef enum logic [1:0] {
      DM_BYTE   = 2'b00,
      DM_HALF   = 2'b01,
      DM_WORD   = 2'b10,
      DM_DOUBLE = 2'b11
   } datamode_e;

   // ##################################################
   // Packet layout
   // ##################################################

   // Most significant field first, 104 bits in total
   typedef struct packed {
      logic [3:0]  ctrlmode;
      logic [31:0] srcaddr;
      logic [31:0] data;
      logic [31:0] dstaddr;
      datamode_e   datamode;
      logic        write;
      logic        access;
   } emesh_fields_s;

   // Field view for packer and serializer
   // Raw view for storage in the FIFO
   typedef union packed {
      emesh_fields_s      fields;
      logic [`ETX_PW-1:0] raw;
   } emesh_packet_u;

endpackage

// ==== hw/etx_fifo_if.sv ====
`timescale 1ns/1ns

interface etx_fifo_if;

   // Oldest entry in the FIFO
   logic                    head_valid;
   etx_pkg::emesh_packet_u  head_packet;

   // Entry right behind the head
   // Used for burst lookahead
   logic                    next_valid;
   etx_pkg::emesh_packet_u  next_packet;

   // Removes the head at the clock edge
   logic                    pop;

   // FIFO side
   modport buffer (
      output head_valid,
      output head_packet,
      output next_valid,
      output next_packet,
      input  pop
   );

   // Serializer side
   modport serializer (
      input  head_valid,
      input  head_packet,
      input  next_valid,
      input  next_packet,
      output pop
   );

endinterface

// ==== hw/etx_packer.sv ====
`timescale 1ns/1ns

module etx_packer (
   input  logic                   tx_lclk,
   input  logic                   ioreset,
   input  logic                   fab_access,
   input  logic                   fab_write,
   input  etx_pkg::datamode_e     fab_datamode,
   input  logic [3:0]             fab_ctrlmode,
   input  logic [31:0]            fab_dstaddr,
   input  logic [31:0]            fab_data,
   input  logic [31:0]            fab_srcaddr,
   output logic                   fab_wait,
   output logic                   push,
   output etx_pkg::emesh_packet_u packet,
   input  logic                   full
);

   logic                   cap_valid;
   etx_pkg::emesh_packet_u cap_packet;
   logic                   accept;

   // ##################################################
   // Fabric handshake
   // ##################################################

   // Stall only when the capture slot is stuck behind a full FIFO
   assign fab_wait = cap_valid & full;
   assign accept   = fab_access & ~fab_wait;

   // Drain into the FIFO whenever it has room
   assign push   = cap_valid & ~full;
   assign packet = cap_packet;

   // Slot occupancy
   always_ff @(posedge tx_lclk or posedge ioreset) begin
      if (ioreset) begin
         cap_valid <= 1'b0;
      end else if (accept) begin
         cap_valid <= 1'b1;
      end else if (push) begin
         cap_valid <= 1'b0;
      end
   end

   // ##################################################
   // Packet assembly
   // ##################################################
   always_ff @(posedge tx_lclk) begin
      if (accept) begin
         cap_packet.fields.ctrlmode <= fab_ctrlmode;
         cap_packet.fields.srcaddr  <= fab_srcaddr;
         cap_packet.fields.data     <= fab_data;
         cap_packet.fields.dstaddr  <= fab_dstaddr;
         cap_packet.fields.datamode <= fab_datamode;
         cap_packet.fields.write    <= fab_write;
         // Every captured transaction is a valid access
         cap_packet.fields.access   <= 1'b1;
      end
   end

   // Stalled request stays on the fabric unchanged until taken
   a_fab_hold : assert property (
      @(posedge tx_lclk) disable iff (ioreset)
         fab_access && fab_wait |=> fab_access
            && $stable({fab_write, fab_datamode, fab_ctrlmode})
            && $stable({fab_dstaddr, fab_data, fab_srcaddr})
   );

endmodule

// ==== hw/etx_fifo.sv ====
`timescale 1ns/1ns
`include "etx_defines.svh"

module etx_fifo (
   input  logic                   tx_lclk,
   input  logic                   ioreset,
   input  logic                   push,
   input  etx_pkg::emesh_packet_u packet,
   output logic                   full,
   etx_fifo_if.buffer             fifo
);

   // Raw packet store
   logic [`ETX_PW-1:0]      mem [`ETX_FIFO_DEPTH];

   logic [`ETX_FIFO_AW-1:0] wr_ptr;
   logic [`ETX_FIFO_AW-1:0] rd_ptr;
   logic [`ETX_FIFO_AW-1:0] nx_ptr;
   logic [`ETX_FIFO_AW:0]   count;
   logic                    do_push;
   logic                    do_pop;

   // ##################################################
   // Flags
   // ##################################################
   assign full    = (count == (`ETX_FIFO_AW+1)'(`ETX_FIFO_DEPTH));
   assign do_pop  = fifo.pop & fifo.head_valid;
   // A pop in the same cycle frees a slot
   assign do_push = push & (~full | do_pop);

   // ##################################################
   // Read side
   // ##################################################

   // Slot behind the head, wraps with the pointer
   assign nx_ptr = rd_ptr + 1'b1;

   assign fifo.head_valid      = (count != '0);
   assign fifo.head_packet.raw = mem[rd_ptr];
   assign fifo.next_valid      = (count > (`ETX_FIFO_AW+1)'(1));
   assign fifo.next_packet.raw = mem[nx_ptr];

   // ##################################################
   // Pointers and count
   // ##################################################
   always_ff @(posedge tx_lclk or posedge ioreset) begin
      if (ioreset) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_push) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (do_pop) begin
            rd_ptr <= nx_ptr;
         end
         case ({do_push, do_pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   // Storage write
   always_ff @(posedge tx_lclk) begin
      if (do_push) begin
         mem[wr_ptr] <= packet.raw;
      end
   end

   // Occupancy bound
   a_count_max : assert property (
      @(posedge tx_lclk) disable iff (ioreset)
         count <= (`ETX_FIFO_AW+1)'(`ETX_FIFO_DEPTH)
   );

   // Serializer only pops an entry that exists
   a_pop_empty : assert property (
      @(posedge tx_lclk) disable iff (ioreset) fifo.pop |-> (count != '0)
   );

endmodule

// ==== hw/etx_io.sv ====
`timescale 1ns/1ns

module etx_io (
   input  logic           tx_lclk,
   input  logic           ioreset,
   etx_fifo_if.serializer fifo,
   input  logic           tx_wr_wait,
   input  logic           tx_rd_wait,
   output logic           txo_frame,
   output logic [7:0]     txo_data
);

   // Head is the packet on the wire, next is the burst candidate
   etx_pkg::emesh_fields_s cur;
   etx_pkg::emesh_fields_s nxt;

   // One bit per byte of the frame
   logic [13:0] tx_pointer;
   logic        busy;
   logic        last;
   logic        blocked;
   logic        start;
   logic        burst;
   logic [7:0]  tx_byte;

   assign cur = fifo.head_packet.fields;
   assign nxt = fifo.next_packet.fields;

   assign busy = |tx_pointer;
   assign last = tx_pointer[13];

   // ##################################################
   // Start and burst decisions
   // ##################################################

   // Pushback of the matching kind
   assign blocked = cur.write ? tx_wr_wait : tx_rd_wait;
   assign start   = ~busy & fifo.head_valid & ~blocked;

   // Next 64-bit write to the following doubleword
   assign burst = cur.write & (cur.datamode == etx_pkg::DM_DOUBLE)
                & fifo.next_valid & nxt.write
                & (nxt.datamode == etx_pkg::DM_DOUBLE)
                & (nxt.ctrlmode == cur.ctrlmode)
                & (nxt.dstaddr == cur.dstaddr + 32'd8)
                & ~tx_wr_wait;

   // Head leaves with its final byte
   assign fifo.pop = last;

   // ##################################################
   // Byte pointer
   // ##################################################
   always_ff @(posedge tx_lclk or posedge ioreset) begin
      if (ioreset) begin
         tx_pointer <= '0;
      end else if (start) begin
         tx_pointer <= 14'h0001;
      end else if (last) begin
         // Continuation skips the header and goes on with data
         tx_pointer <= burst ? 14'h0040 : 14'h0000;
      end else begin
         tx_pointer <= tx_pointer << 1;
      end
   end

   // ##################################################
   // Byte select
   // ##################################################
   always_comb begin
      case (1'b1)
         tx_pointer[0]:  tx_byte = {cur.ctrlmode, cur.dstaddr[31:28]};
         // Read flag in the top bit
         tx_pointer[1]:  tx_byte = {~cur.write, 7'b0};
         tx_pointer[2]:  tx_byte = cur.dstaddr[27:20];
         tx_pointer[3]:  tx_byte = cur.dstaddr[19:12];
         tx_pointer[4]:  tx_byte = cur.dstaddr[11:4];
         tx_pointer[5]:  tx_byte = {cur.dstaddr[3:0], cur.datamode, cur.write, cur.access};
         // Data, high byte first
         tx_pointer[6]:  tx_byte = cur.data[31:24];
         tx_pointer[7]:  tx_byte = cur.data[23:16];
         tx_pointer[8]:  tx_byte = cur.data[15:8];
         tx_pointer[9]:  tx_byte = cur.data[7:0];
         // Source address, high byte first
         tx_pointer[10]: tx_byte = cur.srcaddr[31:24];
         tx_pointer[11]: tx_byte = cur.srcaddr[23:16];
         tx_pointer[12]: tx_byte = cur.srcaddr[15:8];
         tx_pointer[13]: tx_byte = cur.srcaddr[7:0];
         default:        tx_byte = 8'h00;
      endcase
   end

   // Pin registers
   always_ff @(posedge tx_lclk or posedge ioreset) begin
      if (ioreset) begin
         txo_frame <= 1'b0;
         txo_data  <= 8'h00;
      end else begin
         txo_frame <= busy;
         txo_data  <= tx_byte;
      end
   end

   // Shortest frame is one full packet
   a_frame_whole : assert property (
      @(posedge tx_lclk) disable iff (ioreset) $rose(txo_frame) |-> txo_frame[*14]
   );

endmodule

// ==== hw/etx.sv ====
`timescale 1ns/1ns

module etx (
   input  logic        tx_lclk,
   input  logic        ioreset,
   // Fabric side
   input  logic        fab_access,
   input  logic        fab_write,
   input  logic [1:0]  fab_datamode,
   input  logic [3:0]  fab_ctrlmode,
   input  logic [31:0] fab_dstaddr,
   input  logic [31:0] fab_data,
   input  logic [31:0] fab_srcaddr,
   output logic        fab_wait,
   // Link side
   input  logic        tx_wr_wait,
   input  logic        tx_rd_wait,
   output logic        txo_frame,
   output logic [7:0]  txo_data
);

   // Capture to FIFO write side
   logic                   push;
   logic                   full;
   etx_pkg::emesh_packet_u packet;

   // FIFO read side
   etx_fifo_if fifo_if ();

   // ##################################################
   // Capture stage
   // ##################################################
   etx_packer packer0 (
      .tx_lclk      (tx_lclk),
      .ioreset      (ioreset),
      .fab_access   (fab_access),
      .fab_write    (fab_write),
      .fab_datamode (etx_pkg::datamode_e'(fab_datamode)),
      .fab_ctrlmode (fab_ctrlmode),
      .fab_dstaddr  (fab_dstaddr),
      .fab_data     (fab_data),
      .fab_srcaddr  (fab_srcaddr),
      .fab_wait     (fab_wait),
      .push         (push),
      .packet       (packet),
      .full         (full)
   );

   // Packet buffer
   etx_fifo fifo0 (
      .tx_lclk (tx_lclk),
      .ioreset (ioreset),
      .push    (push),
      .packet  (packet),
      .full    (full),
      .fifo    (fifo_if.buffer)
   );

   // ##################################################
   // Serializer
   // ##################################################
   etx_io io0 (
      .tx_lclk    (tx_lclk),
      .ioreset    (ioreset),
      .fifo       (fifo_if.serializer),
      .tx_wr_wait (tx_wr_wait),
      .tx_rd_wait (tx_rd_wait),
      .txo_frame  (txo_frame),
      .txo_data   (txo_data)
   );

endmodule

// ==== testbench/etx_checker.sv ====
`timescale 1ns/1ns

module etx_checker #(
   parameter int MAXROWS = 32
) (
   input  logic                                 tx_lclk,
   input  logic                                 ioreset,
   input  logic                                 txo_frame,
   input  logic [7:0]                           txo_data,
   input  logic                                 tx_wr_wait,
   input  logic                                 fab_wait,
   input  int                                   nrows,
   input  etx_pkg::emesh_fields_s [MAXROWS-1:0] pkts,
   input  logic [MAXROWS-1:0]                   bursts,
   output int                                   done_count,
   output int                                   errors,
   output int                                   reads_in_hold,
   output int                                   wait_cycles
);

   logic prev_frame;
   logic pkt_ok;
   // tx_wr_wait as seen one and two edges back
   logic wr_d1;
   logic wr_d2;
   // Byte position inside the 14-byte image
   // 14 means idle
   int   pos;
   int   cur;

   // ##################################################
   // Expected wire image
   // ##################################################

   // Byte k of a packet, header bytes first, then data and srcaddr
   function automatic logic [7:0] wire_byte(input etx_pkg::emesh_fields_s p, input int k);
      logic [111:0] img;
      img = {p.ctrlmode, p.dstaddr[31:28], ~p.write, 7'b0, p.dstaddr[27:4],
             p.dstaddr[3:0], p.datamode, p.write, 1'b1, p.data, p.srcaddr};
      return img[111 - 8*k -: 8];
   endfunction

   // New packet on the wire
   // Header when frame just rose, else a burst continuation
   task automatic open_packet(input logic header);
      cur    = done_count;
      pos    = header ? 0 : 6;
      pkt_ok = (cur < nrows);
      if (!pkt_ok) begin
         errors++;
         $display("Extra packet on the link after all %0d expected packets", nrows);
      end else begin
         if (header == bursts[cur]) begin
            errors++;
            $display("** Error at %0t: packet %0d sent as %s", $time, cur,
                     header ? "header, expected continuation" : "continuation, expected header");
         end
         // Start decision was taken two edges before the first byte shows
         if (wr_d2 && pkts[cur].write) begin
            errors++;
            $display("** Error at %0t: write packet %0d started under tx_wr_wait",
                     $time, cur);
         end
         if (wr_d2 && !pkts[cur].write) begin
            reads_in_hold++;
         end
      end
   endtask

   // ##################################################
   // Stream monitor
   // ##################################################
   always @(posedge tx_lclk) begin
      if (ioreset) begin
         prev_frame    = 1'b0;
         pkt_ok        = 1'b0;
         wr_d1         = 1'b0;
         wr_d2         = 1'b0;
         pos           = 14;
         cur           = 0;
         done_count    = 0;
         errors        = 0;
         reads_in_hold = 0;
         wait_cycles   = 0;
      end else begin
         // Fabric stall while pushback keeps the FIFO full
         if (fab_wait && tx_wr_wait) begin
            wait_cycles++;
         end
         // Frame rise, or 14 bytes done with frame still high
         if (txo_frame && (!prev_frame || pos == 14)) begin
            open_packet(!prev_frame);
         end
         if (txo_frame) begin
            if (pkt_ok && txo_data !== wire_byte(pkts[cur], pos)) begin
               errors++;
               $display("** Error at %0t: packet %0d byte %0d expected %02h got %02h",
                        $time, cur, pos, wire_byte(pkts[cur], pos), txo_data);
            end
            pos++;
            if (pos == 14 && pkt_ok) begin
               done_count++;
            end
         end else if (prev_frame && pos != 14) begin
            errors++;
            $display("Frame of packet %0d dropped after byte %0d", cur, pos);
            pos = 14;
            // A dropped packet still counts as done
            if (pkt_ok) begin
               done_count++;
            end
         end
         prev_frame = txo_frame;
         wr_d2      = wr_d1;
         wr_d1      = tx_wr_wait;
      end
   end

endmodule

// ==== testbench/tb_etx.sv ====
`timescale 1ns/1ns
`include "etx_defines.svh"

module tb_etx;

   localparam int MAXROWS    = 32;
   localparam int RST_CYCLES = 10;

   logic        tx_lclk;
   logic        ioreset;
   logic        fab_access;
   logic        fab_write;
   logic [1:0]  fab_datamode;
   logic [3:0]  fab_ctrlmode;
   logic [31:0] fab_dstaddr;
   logic [31:0] fab_data;
   logic [31:0] fab_srcaddr;
   logic        fab_wait;
   logic        tx_wr_wait;
   logic        tx_rd_wait;
   logic        txo_frame;
   logic [7:0]  txo_data;

   // Transaction table
   // The checker reads the same rows
   etx_pkg::emesh_fields_s [MAXROWS-1:0] tbl;
   logic [MAXROWS-1:0]                   tbl_burst;
   // Base cycles of tx_wr_wait raised before the row
   // 0 for none
   int                                   tbl_hold [MAXROWS];
   int                                   nrows;

   int done_count;
   int chk_errors;
   int reads_in_hold;
   int wait_cycles;
   int tb_errors;

   etx dut0 (
      .tx_lclk      (tx_lclk),
      .ioreset      (ioreset),
      .fab_access   (fab_access),
      .fab_write    (fab_write),
      .fab_datamode (fab_datamode),
      .fab_ctrlmode (fab_ctrlmode),
      .fab_dstaddr  (fab_dstaddr),
      .fab_data     (fab_data),
      .fab_srcaddr  (fab_srcaddr),
      .fab_wait     (fab_wait),
      .tx_wr_wait   (tx_wr_wait),
      .tx_rd_wait   (tx_rd_wait),
      .txo_frame    (txo_frame),
      .txo_data     (txo_data)
   );

   etx_checker #(.MAXROWS(MAXROWS)) chk0 (
      .tx_lclk       (tx_lclk),
      .ioreset       (ioreset),
      .txo_frame     (txo_frame),
      .txo_data      (txo_data),
      .tx_wr_wait    (tx_wr_wait),
      .fab_wait      (fab_wait),
      .nrows         (nrows),
      .pkts          (tbl),
      .bursts        (tbl_burst),
      .done_count    (done_count),
      .errors        (chk_errors),
      .reads_in_hold (reads_in_hold),
      .wait_cycles   (wait_cycles)
   );

   // ##################################################
   // Clock and watchdog
   // ##################################################
   initial begin
      tx_lclk = 1'b0;
      forever #5 tx_lclk = ~tx_lclk;
   end

   // 40 cycles per row covers the longest pushback hold
   initial begin
      int limit;
      #1;
      limit = RST_CYCLES + 40 * nrows;
      repeat (limit) @(posedge tx_lclk);
      $display("Run timed out after %0d cycles, %0d of %0d packets received",
               limit, done_count, nrows);
      $display("TB FAILED");
      $finish;
   end

   // ##################################################
   // Helpers
   // ##################################################

   // Data and srcaddr are random
   task automatic add_row(input logic w, input logic [1:0] dm, input logic [3:0] cm,
                          input logic [31:0] dst, input logic bst, input int hold);
      etx_pkg::emesh_fields_s f;
      f.ctrlmode       = cm;
      f.srcaddr        = $urandom();
      f.data           = $urandom();
      f.dstaddr        = dst;
      f.datamode       = etx_pkg::datamode_e'(dm);
      f.write          = w;
      f.access         = 1'b1;
      tbl[nrows]       = f;
      tbl_burst[nrows] = bst;
      tbl_hold[nrows]  = hold;
      nrows++;
   endtask

   task automatic release_wr_wait(input int cycles);
      repeat (cycles) @(negedge tx_lclk);
      tx_wr_wait = 1'b0;
   endtask

   // Link quiet and fabric free right after reset
   task automatic check_idle();
      if (txo_frame !== 1'b0 || txo_data !== 8'h00 || fab_wait !== 1'b0) begin
         tb_errors++;
         $display("** Error at %0t: not idle after reset, frame %b data %02h fab_wait %b",
                  $time, txo_frame, txo_data, fab_wait);
      end
   endtask

   // ##################################################
   // Stimulus
   // ##################################################
   initial begin
      int hold;
      void'($urandom(32'h116d82f3));
      ioreset      = 1'b1;
      fab_access   = 1'b0;
      fab_write    = 1'b0;
      fab_datamode = 2'b00;
      fab_ctrlmode = 4'h0;
      fab_dstaddr  = '0;
      fab_data     = '0;
      fab_srcaddr  = '0;
      tx_wr_wait   = 1'b0;
      tx_rd_wait   = 1'b0;
      nrows        = 0;
      tb_errors    = 0;
      tbl_burst    = '0;

      // Single write, single read
      add_row(1'b1, 2'b10, 4'h3, 32'h8000_1234, 1'b0, 0);
      add_row(1'b0, 2'b10, 4'h3, 32'h8000_2000, 1'b0, 0);
      // Doubleword run, then a break in the addresses
      add_row(1'b1, 2'b11, 4'h5, 32'h0000_0100, 1'b0, 0);
      add_row(1'b1, 2'b11, 4'h5, 32'h0000_0108, 1'b1, 0);
      add_row(1'b1, 2'b11, 4'h5, 32'h0000_0110, 1'b1, 0);
      add_row(1'b1, 2'b11, 4'h5, 32'h0000_0118, 1'b1, 0);
      add_row(1'b1, 2'b11, 4'h5, 32'h0000_0200, 1'b0, 0);
      // Read at the head goes out while the writes behind it wait
      add_row(1'b0, 2'b01, 4'h9, 32'h4000_0010, 1'b0, 25);
      add_row(1'b1, 2'b10, 4'h9, 32'h4000_0020, 1'b0, 0);
      add_row(1'b1, 2'b00, 4'h9, 32'h4000_0031, 1'b0, 0);
      // Fill FIFO and capture slot so one more stalls on fab_wait
      for (int k = 0; k < `ETX_FIFO_DEPTH + 2; k++) begin
         add_row(1'b1, 2'b10, 4'hc, 32'h6000_0000 + 32'(k << 4), 1'b0, (k == 0) ? 25 : 0);
      end

      repeat (RST_CYCLES) @(negedge tx_lclk);
      ioreset = 1'b0;
      @(negedge tx_lclk);
      check_idle();

      for (int i = 0; i < nrows; i++) begin
         // Pushback starts from an idle link
         if (tbl_hold[i] != 0) begin
            fab_access = 1'b0;
            wait (done_count == i);
            @(negedge tx_lclk);
            hold       = tbl_hold[i] + $urandom_range(15, 0);
            tx_wr_wait = 1'b1;
            fork
               release_wr_wait(hold);
            join_none
         end
         fab_access   = 1'b1;
         fab_write    = tbl[i].write;
         fab_datamode = tbl[i].datamode;
         fab_ctrlmode = tbl[i].ctrlmode;
         fab_dstaddr  = tbl[i].dstaddr;
         fab_data     = tbl[i].data;
         fab_srcaddr  = tbl[i].srcaddr;
         // Hold the row until the next edge takes it
         while (fab_wait) @(negedge tx_lclk);
         @(negedge tx_lclk);
      end
      fab_access = 1'b0;

      wait (done_count == nrows);
      // Room for any packet that should not be there
      repeat (30) @(negedge tx_lclk);
      if (reads_in_hold == 0) begin
         tb_errors++;
         $display("No read packet went out while tx_wr_wait was high");
      end
      if (wait_cycles == 0) begin
         tb_errors++;
         $display("fab_wait never rose while pushback held the FIFO full");
      end

      $display("Errors: checker %0d, testbench %0d", chk_errors, tb_errors);
      if (chk_errors == 0 && tb_errors == 0) begin
         $display("TB PASSED");
      end else begin
         $display("TB FAILED");
      end
      $finish;
   end

endmodule

// ==== files.f ====
+incdir+hw
hw/etx_pkg.sv
hw/etx_fifo_if.sv
hw/etx_packer.sv
hw/etx_fifo.sv
hw/etx_io.sv
hw/etx.sv
testbench/etx_checker.sv
testbench/tb_etx.sv
